//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module tb_prefix_eval -o Vtb_prefix_eval

run: build
	./obj_dir/Vtb_prefix_eval | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --top-module prefix_eval_top \
		source/prefix_eval_pkg.sv source/stack_ctrl_if.sv source/eval_alu.sv \
		source/reduce_counter.sv source/token_stack.sv source/eval_fsm.sv \
		source/prefix_eval_top.sv

clean:
	rm -rf obj_dir sim.log

//--- dv/prefix_eval_stim.txt
# name, 19 prefix tokens in hex, expected value in hex
# tokens 10..13 are add, sub, mul, div; expected is 41-bit two's complement
all_add 10 10 10 10 10 10 10 10 10 01 02 03 04 05 06 07 08 09 0a 37
all_sub 11 11 11 11 11 11 11 11 11 01 02 03 04 05 06 07 08 09 0a 1ffffffffcb
all_mul 12 12 12 12 12 12 12 12 12 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 086430aac61
all_div 13 13 13 13 13 13 13 13 13 0f 02 01 01 01 01 01 01 01 01 7
mixed_nested 10 10 10 10 11 12 10 03 04 11 09 02 13 0f 04 01 02 03 04 38
alt_sub_mul 11 02 12 03 11 04 12 05 11 06 12 07 11 08 12 09 11 0a 0b 1fffffff957
div_neg_trunc 10 10 10 10 10 10 10 13 11 01 08 02 00 00 00 00 00 00 00 1fffffffffd

//--- dv/tb_prefix_eval.sv
`timescale 1ns/1ps

module tb_prefix_eval;

    localparam int num_count   = 10;
    localparam int tok_count   = 2 * num_count - 1;
    localparam int wait_limit  = 400;
    localparam int num_random  = 200;
    // directed, noise and random cases with some headroom
    localparam int test_budget = 240;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    prefix_eval_pkg::token_t in_data;
    logic                    out_valid;
    prefix_eval_pkg::value_t out;

    prefix_eval_pkg::token_t tokens [tok_count];
    logic [31:0]             rng_state;
    logic                    bad_divisor;
    int                      err_count;
    int                      test_count;

    prefix_eval_top #(
        .num_count (num_count)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out       (out)
    );

    always #4 clk = ~clk;

    //============================================================
    // stimulus generation and reference model
    //============================================================

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // need counts the operands still owed, so the sequence is always a valid prefix
    task automatic make_random_expr();
        int          need;
        int          ops_left;
        logic [31:0] r;
        need     = 1;
        ops_left = num_count - 1;
        for (int i = 0; i < tok_count; i++) begin
            r = xorshift();
            if (ops_left > 0 && (need == 1 || r[8])) begin
                tokens[i] = {3'b100, r[1:0]};
                ops_left--;
                need++;
            end
            else begin
                tokens[i] = {1'b0, r[3:0]};
                need--;
            end
        end
    endtask

    // right to left over the prefix, top of stack is the left operand
    function automatic prefix_eval_pkg::value_t eval_prefix();
        prefix_eval_pkg::value_t vstack [tok_count];
        int                      src    [tok_count];
        int                      sp;
        prefix_eval_pkg::value_t a;
        prefix_eval_pkg::value_t b;
        prefix_eval_pkg::value_t r;
        sp          = 0;
        bad_divisor = 1'b0;
        for (int i = tok_count - 1; i >= 0; i--) begin
            if (!tokens[i][4]) begin
                vstack[sp] = {37'd0, tokens[i][3:0]};
                src[sp]    = i;
                sp++;
            end
            else begin
                a = vstack[sp-1];
                b = vstack[sp-2];
                if (tokens[i][1:0] == 2'd3 && b == 0) begin
                    // a plain zero divisor becomes one
                    if (src[sp-2] >= 0) begin
                        tokens[src[sp-2]] = 5'h01;
                    end
                    else begin
                        bad_divisor = 1'b1;
                    end
                    b = 41'sd1;
                end
                case (tokens[i][1:0])
                    2'd0: r = a + b;
                    2'd1: r = a - b;
                    2'd2: r = a * b;
                    default: r = a / b;
                endcase
                sp         = sp - 2;
                vstack[sp] = r;
                src[sp]    = -1;
                sp++;
            end
        end
        return vstack[0];
    endfunction

    task automatic next_random_case(output prefix_eval_pkg::value_t expected);
        do begin
            make_random_expr();
            expected = eval_prefix();
        end while (bad_divisor);
    endtask

    //============================================================
    // driving and checking
    //============================================================

    task automatic run_expr(input string name, input prefix_eval_pkg::value_t expected,
                            input bit noise);
        int          cycles;
        logic [31:0] r;
        test_count++;
        for (int i = 0; i < tok_count; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = tokens[i];
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
        cycles   = 0;
        while (!out_valid && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
            // junk on the inputs while the result is pending
            if (noise && !out_valid) begin
                r        = xorshift();
                in_valid = r[0];
                in_data  = r[8:4];
            end
        end
        in_valid = 1'b0;
        in_data  = '0;
        if (!out_valid) begin
            $display("%s: out_valid did not rise within %0d cycles", name, wait_limit);
            err_count++;
        end
        else begin
            if (out !== expected) begin
                $display("MISMATCH %s: expected %h, actual %h", name, expected, out);
                err_count++;
            end
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("%s: out_valid stayed high for more than one cycle", name);
                err_count++;
            end
            if (out !== '0) begin
                $display("MISMATCH %s after pulse: expected %h, actual %h", name, 41'd0, out);
                err_count++;
            end
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic run_file_cases();
        int                      fd;
        int                      n;
        string                   name;
        string                   rest;
        logic [31:0]             tok;
        logic [40:0]             word;
        prefix_eval_pkg::value_t expected;
        fd = $fopen("dv/prefix_eval_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/prefix_eval_stim.txt");
            err_count++;
            return;
        end
        while ($fscanf(fd, "%s", name) == 1) begin
            if (name.getc(0) == "#") begin
                n = $fgets(rest, fd);
            end
            else begin
                for (int i = 0; i < tok_count; i++) begin
                    n = $fscanf(fd, "%h", tok);
                    if (n != 1) begin
                        $display("%s: a token is missing in the stimulus file", name);
                        err_count++;
                    end
                    tokens[i] = tok[4:0];
                end
                n = $fscanf(fd, "%h", word);
                if (n != 1) begin
                    $display("%s: the expected value is missing in the stimulus file", name);
                    err_count++;
                end
                expected = word;
                run_expr(name, expected, 1'b0);
            end
        end
        $fclose(fd);
    endtask

    //============================================================
    // main sequence
    //============================================================

    initial begin
        prefix_eval_pkg::value_t expected;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        rng_state  = 32'h194;
        err_count  = 0;
        test_count = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("out_valid is high after reset with no input");
            err_count++;
        end
        if (out !== '0) begin
            $display("MISMATCH after_reset: expected %h, actual %h", 41'd0, out);
            err_count++;
        end

        run_file_cases();

        // pending result must survive input noise, and the next one start clean
        next_random_case(expected);
        run_expr("pending_noise", expected, 1'b1);
        next_random_case(expected);
        run_expr("after_noise", expected, 1'b0);

        for (int k = 0; k < num_random; k++) begin
            next_random_case(expected);
            run_expr($sformatf("random_%0d", k), expected, 1'b0);
        end

        $display("tests run: %0d, errors: %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(test_budget * wait_limit * 8);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- flist.f
source/prefix_eval_pkg.sv
source/stack_ctrl_if.sv
source/eval_alu.sv
source/reduce_counter.sv
source/token_stack.sv
source/eval_fsm.sv
source/prefix_eval_top.sv
dv/tb_prefix_eval.sv

//--- source/eval_alu.sv
`timescale 1ns/1ps

module eval_alu (
    input  prefix_eval_pkg::value_t lhs,
    input  prefix_eval_pkg::value_t rhs,
    input  prefix_eval_pkg::op_e    opcode,
    output prefix_eval_pkg::value_t result
);

    // signed, division truncates toward zero
    always_comb begin
        case (opcode)
            prefix_eval_pkg::op_add: begin
                result = lhs + rhs;
            end
            prefix_eval_pkg::op_sub: begin
                result = lhs - rhs;
            end
            prefix_eval_pkg::op_mul: begin
                result = lhs * rhs;
            end
            prefix_eval_pkg::op_div: begin
                result = lhs / rhs;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- source/eval_fsm.sv
`timescale 1ns/1ps

module eval_fsm #(
    parameter int num_count = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    stack_ctrl_if.fsm               ctl,
    input  prefix_eval_pkg::value_t top_value,
    output logic                    out_valid,
    output prefix_eval_pkg::value_t out
);

    localparam int depth = 2 * num_count - 1;

    prefix_eval_pkg::state_e state;
    prefix_eval_pkg::state_e state_nxt;
    logic                    done;

    //============================================================
    // state register
    //============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= prefix_eval_pkg::st_idle;
        end
        else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            prefix_eval_pkg::st_idle: begin
                if (in_valid) begin
                    state_nxt = prefix_eval_pkg::st_load;
                end
            end
            // last token lands in the stack on the cycle in_valid drops
            prefix_eval_pkg::st_load: begin
                if (!in_valid) begin
                    state_nxt = prefix_eval_pkg::st_eval;
                end
            end
            prefix_eval_pkg::st_eval: begin
                if (ctl.reduce) begin
                    state_nxt = prefix_eval_pkg::st_check;
                end
            end
            prefix_eval_pkg::st_check: begin
                if (ctl.all_reduced) begin
                    state_nxt = prefix_eval_pkg::st_out;
                end
                else begin
                    state_nxt = prefix_eval_pkg::st_eval;
                end
            end
            default: begin
                state_nxt = prefix_eval_pkg::st_idle;
            end
        endcase
    end

    assign ctl.clear    = (state == prefix_eval_pkg::st_idle);
    assign ctl.load     = (state == prefix_eval_pkg::st_load);
    assign ctl.scanning = (state == prefix_eval_pkg::st_eval);
    assign ctl.reduce   = ctl.scanning && ctl.match;

    //============================================================
    // result
    //============================================================

    assign done = (state == prefix_eval_pkg::st_check) && ctl.all_reduced;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end
        else begin
            out_valid <= done;
            out       <= done ? top_value : '0;
        end
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid
    );

    // a window must turn up before the scan runs off the stack
    a_eval_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == prefix_eval_pkg::st_eval) |-> ##[0:depth] (state != prefix_eval_pkg::st_eval)
    );

endmodule

//--- source/prefix_eval_pkg.sv
package prefix_eval_pkg;

    //============================================================
    // widths
    //============================================================

    parameter int token_w = 5;
    parameter int value_w = 41;

    // scan index, enough for 31 stack entries
    parameter int idx_w = 5;

    //============================================================
    // types
    //============================================================

    // bit 4 marks an operator, bits 3:0 the number
    typedef logic [token_w-1:0] token_t;

    typedef logic signed [value_w-1:0] value_t;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2,
        op_div = 2'd3
    } op_e;

    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_load  = 3'd1,
        st_eval  = 3'd2,
        st_check = 3'd3,
        st_out   = 3'd4
    } state_e;

endpackage

//--- source/prefix_eval_top.sv
`timescale 1ns/1ps

module prefix_eval_top #(
    parameter int num_count = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  prefix_eval_pkg::token_t in_data,
    output logic                    out_valid,
    output prefix_eval_pkg::value_t out
);

    prefix_eval_pkg::value_t lhs;
    prefix_eval_pkg::value_t rhs;
    prefix_eval_pkg::value_t result;
    prefix_eval_pkg::value_t top_value;
    prefix_eval_pkg::op_e    opcode;

    stack_ctrl_if ctl_if ();

    eval_fsm #(
        .num_count (num_count)
    ) u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ctl       (ctl_if.fsm),
        .top_value (top_value),
        .out_valid (out_valid),
        .out       (out)
    );

    reduce_counter #(
        .num_count (num_count)
    ) u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .ctl   (ctl_if.ctr)
    );

    token_stack #(
        .num_count (num_count)
    ) u_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .ctl       (ctl_if.stk),
        .lhs       (lhs),
        .rhs       (rhs),
        .opcode    (opcode),
        .result    (result),
        .top_value (top_value)
    );

    eval_alu u_alu (
        .lhs    (lhs),
        .rhs    (rhs),
        .opcode (opcode),
        .result (result)
    );

endmodule

//--- source/reduce_counter.sv
`timescale 1ns/1ps

module reduce_counter #(
    parameter int num_count = 10
) (
    input  logic      clk,
    input  logic      rst_n,
    stack_ctrl_if.ctr ctl
);

    localparam int depth = 2 * num_count - 1;
    localparam int cnt_w = $clog2(num_count + 1);

    logic [prefix_eval_pkg::idx_w-1:0] scan_idx;
    logic [cnt_w-1:0]                  red_cnt;

    // scan position, restarts from the bottom after each collapse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_idx <= '0;
        end
        else if (ctl.reduce || !ctl.scanning) begin
            scan_idx <= '0;
        end
        else begin
            scan_idx <= scan_idx + 1'b1;
        end
    end

    // completed collapses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red_cnt <= '0;
        end
        else if (ctl.clear) begin
            red_cnt <= '0;
        end
        else if (ctl.reduce) begin
            red_cnt <= red_cnt + 1'b1;
        end
    end

    assign ctl.scan_idx    = scan_idx;
    assign ctl.all_reduced = (red_cnt == cnt_w'(num_count - 1));

    a_scan_in_stack: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctl.scanning |-> (int'(scan_idx) <= depth - 3)
    );

endmodule

//--- source/stack_ctrl_if.sv
`timescale 1ns/1ps

interface stack_ctrl_if;

    logic                              clear;
    logic                              load;
    logic                              scanning;
    logic                              reduce;
    logic                              match;
    logic                              all_reduced;
    logic [prefix_eval_pkg::idx_w-1:0] scan_idx;

    modport fsm (
        output clear, load, scanning, reduce,
        input  match, all_reduced
    );

    modport ctr (
        input  clear, scanning, reduce,
        output scan_idx, all_reduced
    );

    modport stk (
        input  clear, load, reduce, scan_idx,
        output match
    );

endinterface

//--- source/token_stack.sv
`timescale 1ns/1ps

module token_stack #(
    parameter int num_count = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  prefix_eval_pkg::token_t in_data,
    stack_ctrl_if.stk               ctl,
    output prefix_eval_pkg::value_t lhs,
    output prefix_eval_pkg::value_t rhs,
    output prefix_eval_pkg::op_e    opcode,
    input  prefix_eval_pkg::value_t result,
    output prefix_eval_pkg::value_t top_value
);

    localparam int depth = 2 * num_count - 1;

    prefix_eval_pkg::token_t           tok_reg;
    prefix_eval_pkg::value_t           vals    [depth];
    logic                              num_tag [depth];
    logic                              op_tag  [depth];
    logic [prefix_eval_pkg::idx_w-1:0] idx1;
    logic [prefix_eval_pkg::idx_w-1:0] idx2;

    //============================================================
    // input token
    //============================================================

    always_ff @(posedge clk) begin
        if (in_valid) begin
            tok_reg <= in_data;
        end
    end

    //============================================================
    // value and tag stacks
    //============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                vals[i]    <= '0;
                num_tag[i] <= 1'b0;
                op_tag[i]  <= 1'b0;
            end
        end
        else if (ctl.clear) begin
            for (int i = 0; i < depth; i++) begin
                vals[i]    <= '0;
                num_tag[i] <= 1'b0;
                op_tag[i]  <= 1'b0;
            end
        end
        else if (ctl.load) begin
            // newest token at the bottom, so the stack ends up reversed
            vals[0]    <= prefix_eval_pkg::value_t'(tok_reg[3:0]);
            num_tag[0] <= !tok_reg[4];
            op_tag[0]  <= tok_reg[4];
            for (int i = 1; i < depth; i++) begin
                vals[i]    <= vals[i-1];
                num_tag[i] <= num_tag[i-1];
                op_tag[i]  <= op_tag[i-1];
            end
        end
        else if (ctl.reduce) begin
            for (int i = 0; i < depth; i++) begin
                if (i == int'(ctl.scan_idx)) begin
                    vals[i]    <= result;
                    num_tag[i] <= 1'b1;
                    op_tag[i]  <= 1'b0;
                end
                else if (i > int'(ctl.scan_idx)) begin
                    // drop the two consumed entries, zeros fill the top
                    if (i + 2 < depth) begin
                        vals[i]    <= vals[i+2];
                        num_tag[i] <= num_tag[i+2];
                        op_tag[i]  <= op_tag[i+2];
                    end
                    else begin
                        vals[i]    <= '0;
                        num_tag[i] <= 1'b0;
                        op_tag[i]  <= 1'b0;
                    end
                end
            end
        end
    end

    //============================================================
    // window at scan_idx
    //============================================================

    assign idx1 = ctl.scan_idx + 1'b1;
    assign idx2 = ctl.scan_idx + 2'd2;

    assign rhs    = vals[ctl.scan_idx];
    assign lhs    = vals[idx1];
    assign opcode = prefix_eval_pkg::op_e'(vals[idx2][1:0]);

    // number, number, operator
    assign ctl.match = num_tag[ctl.scan_idx] && num_tag[idx1] && op_tag[idx2];

    assign top_value = vals[0];

    a_match_in_stack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ctl.match) |-> (int'(ctl.scan_idx) + 2 < depth)
    );

endmodule
